//--- bench/clock_gen.sv
// Bench clock and reset source, 125 MHz clock with reset held for the
// first few cycles

`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int RESET_CYCLES = 5
) (
    output logic clk_125mhz,
    output logic rst_125mhz
);

    // 8 ns period
    initial begin
        clk_125mhz = 1'b0;
        forever #4 clk_125mhz = ~clk_125mhz;
    end

    // Released just after an edge, like the rest of the stimulus
    initial begin
        rst_125mhz = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_125mhz);
        #1;
        rst_125mhz = 1'b0;
    end

endmodule

`default_nettype wire

//--- bench/tb_udp_echo.sv
// Self-checking bench for the UDP echo core: random frames in, replies
// checked against a reference model under random output stalls

`timescale 1ns/1ps
`default_nettype none

module tb_udp_echo import udp_echo_pkg::*;;

    localparam int NUM_FRAMES = 60;
    localparam int MAX_LEN = 40;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 200 + 1000;

    logic        clk_125mhz;
    logic        rst_125mhz;
    logic        rx_hdr_valid, rx_hdr_ready;
    ip_addr_t    rx_source_ip;
    udp_port_t   rx_source_port, rx_dest_port;
    udp_length_t rx_length;
    byte_t       rx_payload_tdata;
    logic        rx_payload_tvalid, rx_payload_tready, rx_payload_tlast, rx_payload_tuser;
    logic        tx_hdr_valid, tx_hdr_ready;
    ip_addr_t    tx_dest_ip;
    udp_port_t   tx_source_port, tx_dest_port;
    udp_length_t tx_length;
    byte_t       tx_payload_tdata;
    logic        tx_payload_tvalid, tx_payload_tready, tx_payload_tlast, tx_payload_tuser;
    byte_t       led;

    // Generated frames
    ip_addr_t  frame_ip [NUM_FRAMES];
    udp_port_t frame_sport [NUM_FRAMES];
    udp_port_t frame_dport [NUM_FRAMES];
    int        frame_len [NUM_FRAMES];
    logic      frame_user [NUM_FRAMES];
    byte_t     payload [NUM_FRAMES][MAX_LEN];

    // Expected replies {dest_ip, source_port, dest_port, length} and beats {user, last, data}
    logic [79:0] exp_hdrs[$];
    logic [9:0]  exp_beats[$];
    byte_t       led_expected = '0;
    logic        out_first_beat = 1'b1;

    logic [31:0] stim_state = 32'd7;
    logic [31:0] stall_state = ~32'd7;

    clock_gen #(.RESET_CYCLES(5)) i_clock_gen (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(rst_125mhz)
    );

    udp_echo_top i_dut (.*);

    bind udp_echo_top udp_echo_properties i_props (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    // Reply for one input header, MSB clear when the frame is not answered
    function automatic logic [80:0] expected_reply(input ip_addr_t src_ip,
            input udp_port_t src_port, input udp_port_t dst_port, input udp_length_t len);
        if (dst_port != DEFAULT_ECHO_PORT) begin
            return '0;
        end
        return {1'b1, src_ip, dst_port, src_port, len};
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        stop_on_error($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic build_frames();
        logic [80:0] reply;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            stim_state = xorshift32(stim_state);
            frame_ip[f] = stim_state;
            stim_state = xorshift32(stim_state);
            frame_sport[f] = stim_state[15:0];
            // Every other frame goes to the echo port
            frame_dport[f] = (f % 2 == 0) ? DEFAULT_ECHO_PORT : stim_state[31:16];
            stim_state = xorshift32(stim_state);
            frame_len[f] = int'(stim_state % 32'd40) + 1;
            frame_user[f] = stim_state[31];
            reply = expected_reply(frame_ip[f], frame_sport[f], frame_dport[f],
                udp_length_t'(frame_len[f] + 8));
            if (reply[80]) begin
                exp_hdrs.push_back(reply[79:0]);
            end
            for (int b = 0; b < frame_len[f]; b++) begin
                stim_state = xorshift32(stim_state);
                payload[f][b] = stim_state[7:0];
                if (reply[80]) begin
                    exp_beats.push_back({(b == frame_len[f] - 1) && frame_user[f],
                        b == frame_len[f] - 1, stim_state[7:0]});
                end
            end
        end
    endtask

    // Ready is sampled at the falling edge, the transfer is on the next rising edge
    task automatic send_frame(input int f);
        rx_source_ip = frame_ip[f];
        rx_source_port = frame_sport[f];
        rx_dest_port = frame_dport[f];
        rx_length = udp_length_t'(frame_len[f] + 8);
        rx_hdr_valid = 1'b1;
        @(negedge clk_125mhz);
        while (!rx_hdr_ready) @(negedge clk_125mhz);
        @(posedge clk_125mhz);
        #1;
        rx_hdr_valid = 1'b0;
        for (int b = 0; b < frame_len[f]; b++) begin
            rx_payload_tdata = payload[f][b];
            rx_payload_tlast = (b == frame_len[f] - 1);
            rx_payload_tuser = (b == frame_len[f] - 1) && frame_user[f];
            rx_payload_tvalid = 1'b1;
            @(negedge clk_125mhz);
            while (!rx_payload_tready) @(negedge clk_125mhz);
            @(posedge clk_125mhz);
            #1;
        end
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast = 1'b0;
        rx_payload_tuser = 1'b0;
    endtask

    task automatic check_header();
        logic [79:0] exp;
        assert (exp_hdrs.size() != 0)
            else stop_on_error("reply header seen with no echoed frame outstanding");
        if (exp_hdrs.size() != 0) begin
            exp = exp_hdrs.pop_front();
            assert (tx_dest_ip == exp[79:48])
                else report_mismatch("tx_dest_ip", tx_dest_ip, exp[79:48]);
            assert (tx_source_port == exp[47:32])
                else report_mismatch("tx_source_port", 32'(tx_source_port), 32'(exp[47:32]));
            assert (tx_dest_port == exp[31:16])
                else report_mismatch("tx_dest_port", 32'(tx_dest_port), 32'(exp[31:16]));
            assert (tx_length == exp[15:0])
                else report_mismatch("tx_length", 32'(tx_length), 32'(exp[15:0]));
        end
    endtask

    task automatic check_beat();
        logic [9:0] exp;
        assert (exp_beats.size() != 0)
            else stop_on_error("reply payload byte seen with no echoed byte outstanding");
        if (exp_beats.size() != 0) begin
            exp = exp_beats.pop_front();
            assert (tx_payload_tdata == exp[7:0])
                else report_mismatch("tx_payload_tdata", 32'(tx_payload_tdata), 32'(exp[7:0]));
            assert (tx_payload_tlast == exp[8])
                else report_mismatch("tx_payload_tlast", 32'(tx_payload_tlast), 32'(exp[8]));
            assert (tx_payload_tuser == exp[9])
                else report_mismatch("tx_payload_tuser", 32'(tx_payload_tuser), 32'(exp[9]));
            if (out_first_beat) begin
                led_expected = exp[7:0];
            end
            out_first_beat = exp[8];
        end
    endtask

    // Compare every output handshake with the reference queues
    always @(negedge clk_125mhz) begin
        if (!rst_125mhz) begin
            assert (led == led_expected)
                else report_mismatch("led", 32'(led), 32'(led_expected));
            if (tx_hdr_valid && tx_hdr_ready) begin
                check_header();
            end
            if (tx_payload_tvalid && tx_payload_tready) begin
                check_beat();
            end
        end
    end

    // Random output stalls, with one long mostly stalled stretch to fill the buffer
    initial begin : ready_stalls
        int cycle;
        cycle = 0;
        tx_hdr_ready = 1'b0;
        tx_payload_tready = 1'b0;
        forever begin
            @(posedge clk_125mhz);
            #1;
            stall_state = xorshift32(stall_state);
            cycle++;
            tx_hdr_ready = stall_state[0] | stall_state[1];
            if (cycle >= 300 && cycle < 1000) begin
                tx_payload_tready = (stall_state[5:2] == 4'd0);
            end else begin
                tx_payload_tready = stall_state[6] | stall_state[7];
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk_125mhz);
        stop_on_error("timeout: the echo replies did not all arrive in time");
    end

    initial begin : stimulus
        rx_hdr_valid = 1'b0;
        rx_source_ip = '0;
        rx_source_port = '0;
        rx_dest_port = '0;
        rx_length = '0;
        rx_payload_tdata = '0;
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast = 1'b0;
        rx_payload_tuser = 1'b0;
        build_frames();
        do @(posedge clk_125mhz); while (rst_125mhz);
        @(negedge clk_125mhz);
        assert (!tx_hdr_valid && !tx_payload_tvalid && led == '0)
            else stop_on_error("outputs not idle after reset");
        @(posedge clk_125mhz);
        #1;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame(f);
        end
        while (exp_hdrs.size() != 0 || exp_beats.size() != 0) @(negedge clk_125mhz);
        // Room for late extra replies and the last LED update
        repeat (50) @(negedge clk_125mhz);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/udp_echo_properties.sv
// Handshake properties of the echo core, bound to udp_echo_top
// Checks stable outputs under stall and payload gating on the input side

`timescale 1ns/1ps
`default_nettype none

module udp_echo_properties import udp_echo_pkg::*; (
    input logic        clk_125mhz,
    input logic        rst_125mhz,
    input logic        rx_hdr_valid,
    input logic        rx_hdr_ready,
    input logic        rx_payload_tvalid,
    input logic        rx_payload_tready,
    input logic        rx_payload_tlast,
    input logic        tx_hdr_valid,
    input logic        tx_hdr_ready,
    input ip_addr_t    tx_dest_ip,
    input udp_port_t   tx_source_port,
    input udp_port_t   tx_dest_port,
    input udp_length_t tx_length,
    input logic        tx_payload_tvalid,
    input logic        tx_payload_tready,
    input byte_t       tx_payload_tdata,
    input logic        tx_payload_tlast,
    input logic        tx_payload_tuser
);

    // Header taken and its last payload beat not yet seen
    logic hdr_open;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            hdr_open <= 1'b0;
        end else if (rx_hdr_valid && rx_hdr_ready) begin
            hdr_open <= 1'b1;
        end else if (rx_payload_tvalid && rx_payload_tready && rx_payload_tlast) begin
            hdr_open <= 1'b0;
        end
    end

    tx_hdr_held: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid &&
            $stable({tx_dest_ip, tx_source_port, tx_dest_port, tx_length}))
        else $error("tx header dropped or changed before it was accepted");

    tx_payload_held: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        tx_payload_tvalid && !tx_payload_tready |=> tx_payload_tvalid &&
            $stable({tx_payload_tdata, tx_payload_tlast, tx_payload_tuser}))
        else $error("tx payload beat dropped or changed before it was accepted");

    rx_payload_gated: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        !hdr_open |-> !rx_payload_tready)
        else $error("rx payload ready raised with no header accepted");

endmodule

`default_nettype wire

//--- rtl/udp_echo_pkg.sv
// Shared field types and default settings for the UDP echo core
// Imported by every RTL module and by the bench

`default_nettype none

package udp_echo_pkg;

    // IPv4 address
    typedef logic [31:0] ip_addr_t;

    // UDP port number
    typedef logic [15:0] udp_port_t;

    // UDP length field, header plus payload in bytes
    typedef logic [15:0] udp_length_t;

    // Payload byte, also the LED value
    typedef logic [7:0] byte_t;

    // Destination port that gets an echo reply
    localparam udp_port_t DEFAULT_ECHO_PORT = 16'd1234;

    // Payload buffer depth in bytes, power of two
    localparam int unsigned DEFAULT_FIFO_DEPTH = 32'd256;

endpackage

`default_nettype wire

//--- rtl/udp_echo_top.sv
// Top level of the UDP echo core: filter, payload buffer and reply stage
// Echo port and buffer depth are set here and passed down

`timescale 1ns/1ps
`default_nettype none

module udp_echo_top import udp_echo_pkg::*; #(
    parameter udp_port_t   ECHO_PORT = DEFAULT_ECHO_PORT,
    parameter int unsigned FIFO_DEPTH = DEFAULT_FIFO_DEPTH
) (
    input  logic        clk_125mhz,
    input  logic        rst_125mhz,

    // Parsed UDP datagram in
    input  logic        rx_hdr_valid,
    output logic        rx_hdr_ready,
    input  ip_addr_t    rx_source_ip,
    input  udp_port_t   rx_source_port,
    input  udp_port_t   rx_dest_port,
    input  udp_length_t rx_length,
    input  byte_t       rx_payload_tdata,
    input  logic        rx_payload_tvalid,
    output logic        rx_payload_tready,
    input  logic        rx_payload_tlast,
    input  logic        rx_payload_tuser,

    // Reply datagram out
    output logic        tx_hdr_valid,
    input  logic        tx_hdr_ready,
    output ip_addr_t    tx_dest_ip,
    output udp_port_t   tx_source_port,
    output udp_port_t   tx_dest_port,
    output udp_length_t tx_length,
    output byte_t       tx_payload_tdata,
    output logic        tx_payload_tvalid,
    input  logic        tx_payload_tready,
    output logic        tx_payload_tlast,
    output logic        tx_payload_tuser,

    output byte_t       led
);

    // Reply header between filter and reply stage
    logic        echo_hdr_valid;
    logic        echo_hdr_ready;
    ip_addr_t    echo_dest_ip;
    udp_port_t   echo_source_port;
    udp_port_t   echo_dest_port;
    udp_length_t echo_length;

    // Buffer write side
    byte_t wr_data;
    logic  wr_last;
    logic  wr_user;
    logic  wr_valid;
    logic  wr_ready;

    // Buffer read side
    byte_t rd_data;
    logic  rd_last;
    logic  rd_user;
    logic  rd_valid;
    logic  rd_ready;

    udp_rx_filter #(
        .ECHO_PORT(ECHO_PORT)
    ) i_rx_filter (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(rst_125mhz),
        .rx_hdr_valid(rx_hdr_valid),
        .rx_hdr_ready(rx_hdr_ready),
        .rx_source_ip(rx_source_ip),
        .rx_source_port(rx_source_port),
        .rx_dest_port(rx_dest_port),
        .rx_length(rx_length),
        .rx_payload_tdata(rx_payload_tdata),
        .rx_payload_tvalid(rx_payload_tvalid),
        .rx_payload_tready(rx_payload_tready),
        .rx_payload_tlast(rx_payload_tlast),
        .rx_payload_tuser(rx_payload_tuser),
        .echo_hdr_valid(echo_hdr_valid),
        .echo_hdr_ready(echo_hdr_ready),
        .echo_dest_ip(echo_dest_ip),
        .echo_source_port(echo_source_port),
        .echo_dest_port(echo_dest_port),
        .echo_length(echo_length),
        .wr_data(wr_data),
        .wr_last(wr_last),
        .wr_user(wr_user),
        .wr_valid(wr_valid),
        .wr_ready(wr_ready)
    );

    udp_payload_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_payload_fifo (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(rst_125mhz),
        .wr_data(wr_data),
        .wr_last(wr_last),
        .wr_user(wr_user),
        .wr_valid(wr_valid),
        .wr_ready(wr_ready),
        .rd_data(rd_data),
        .rd_last(rd_last),
        .rd_user(rd_user),
        .rd_valid(rd_valid),
        .rd_ready(rd_ready)
    );

    udp_echo_tx i_echo_tx (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(rst_125mhz),
        .echo_hdr_valid(echo_hdr_valid),
        .echo_hdr_ready(echo_hdr_ready),
        .echo_dest_ip(echo_dest_ip),
        .echo_source_port(echo_source_port),
        .echo_dest_port(echo_dest_port),
        .echo_length(echo_length),
        .tx_hdr_valid(tx_hdr_valid),
        .tx_hdr_ready(tx_hdr_ready),
        .tx_dest_ip(tx_dest_ip),
        .tx_source_port(tx_source_port),
        .tx_dest_port(tx_dest_port),
        .tx_length(tx_length),
        .rd_data(rd_data),
        .rd_last(rd_last),
        .rd_user(rd_user),
        .rd_valid(rd_valid),
        .rd_ready(rd_ready),
        .tx_payload_tdata(tx_payload_tdata),
        .tx_payload_tvalid(tx_payload_tvalid),
        .tx_payload_tready(tx_payload_tready),
        .tx_payload_tlast(tx_payload_tlast),
        .tx_payload_tuser(tx_payload_tuser),
        .led(led)
    );

endmodule

`default_nettype wire

//--- rtl/udp_echo_tx.sv
// Reply stage: holds one reply header until it is taken downstream,
// forwards the buffered payload and shows each frame's first byte on the LEDs

`timescale 1ns/1ps
`default_nettype none

module udp_echo_tx import udp_echo_pkg::*; (
    input  logic        clk_125mhz,
    input  logic        rst_125mhz,

    // Reply header from the filter
    input  logic        echo_hdr_valid,
    output logic        echo_hdr_ready,
    input  ip_addr_t    echo_dest_ip,
    input  udp_port_t   echo_source_port,
    input  udp_port_t   echo_dest_port,
    input  udp_length_t echo_length,

    // Reply header out
    output logic        tx_hdr_valid,
    input  logic        tx_hdr_ready,
    output ip_addr_t    tx_dest_ip,
    output udp_port_t   tx_source_port,
    output udp_port_t   tx_dest_port,
    output udp_length_t tx_length,

    // Payload from the buffer
    input  byte_t       rd_data,
    input  logic        rd_last,
    input  logic        rd_user,
    input  logic        rd_valid,
    output logic        rd_ready,

    // Payload out
    output byte_t       tx_payload_tdata,
    output logic        tx_payload_tvalid,
    input  logic        tx_payload_tready,
    output logic        tx_payload_tlast,
    output logic        tx_payload_tuser,

    output byte_t       led
);

    logic        hdr_valid_reg;
    ip_addr_t    dest_ip_reg;
    udp_port_t   source_port_reg;
    udp_port_t   dest_port_reg;
    udp_length_t length_reg;

    logic  first_beat;
    logic  beat_fire;
    byte_t led_reg;

    // Single header slot
    assign echo_hdr_ready = !hdr_valid_reg;

    assign tx_hdr_valid = hdr_valid_reg;
    assign tx_dest_ip = dest_ip_reg;
    assign tx_source_port = source_port_reg;
    assign tx_dest_port = dest_port_reg;
    assign tx_length = length_reg;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            hdr_valid_reg <= 1'b0;
        end else if (echo_hdr_valid && echo_hdr_ready) begin
            hdr_valid_reg <= 1'b1;
        end else if (tx_hdr_ready) begin
            hdr_valid_reg <= 1'b0;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (echo_hdr_valid && echo_hdr_ready) begin
            dest_ip_reg <= echo_dest_ip;
            source_port_reg <= echo_source_port;
            dest_port_reg <= echo_dest_port;
            length_reg <= echo_length;
        end
    end

    // Payload goes out as it leaves the buffer
    assign tx_payload_tdata = rd_data;
    assign tx_payload_tvalid = rd_valid;
    assign tx_payload_tlast = rd_last;
    assign tx_payload_tuser = rd_user;
    assign rd_ready = tx_payload_tready;

    assign beat_fire = rd_valid && tx_payload_tready;

    // Next accepted byte after a last beat opens a new frame
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            first_beat <= 1'b1;
            led_reg <= '0;
        end else if (beat_fire) begin
            if (first_beat) begin
                led_reg <= rd_data;
            end
            first_beat <= rd_last;
        end
    end

    assign led = led_reg;

endmodule

`default_nettype wire

//--- rtl/udp_payload_fifo.sv
// First-word-fall-through byte buffer for echoed payload, keeping last and
// user with each byte; FIFO_DEPTH must be a power of two

`timescale 1ns/1ps
`default_nettype none

module udp_payload_fifo import udp_echo_pkg::*; #(
    parameter int unsigned FIFO_DEPTH = DEFAULT_FIFO_DEPTH
) (
    input  logic  clk_125mhz,
    input  logic  rst_125mhz,

    // Write side
    input  byte_t wr_data,
    input  logic  wr_last,
    input  logic  wr_user,
    input  logic  wr_valid,
    output logic  wr_ready,

    // Read side, head entry shown while rd_valid is high
    output byte_t rd_data,
    output logic  rd_last,
    output logic  rd_user,
    output logic  rd_valid,
    input  logic  rd_ready
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    localparam int PTR_W = ADDR_W + 1;
    localparam int ENTRY_W = $bits(byte_t) + 2;

    // Entry layout is {user, last, data}
    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];

    // Extra MSB tells a full buffer from an empty one
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr_nxt;
    logic [PTR_W-1:0] rd_ptr_nxt;

    logic [ENTRY_W-1:0] head;
    logic full;
    logic wr_fire;
    logic rd_fire;
    logic rd_valid_reg;

    assign full = (wr_ptr == {~rd_ptr[ADDR_W], rd_ptr[ADDR_W-1:0]});
    assign wr_ready = !full;

    assign wr_fire = wr_valid && !full;
    assign rd_fire = rd_valid_reg && rd_ready;

    assign wr_ptr_nxt = wr_ptr + PTR_W'(wr_fire);
    assign rd_ptr_nxt = rd_ptr + PTR_W'(rd_fire);

    // Head entry read straight from the array
    assign head = mem[rd_ptr[ADDR_W-1:0]];
    assign rd_data = head[$bits(byte_t)-1:0];
    assign rd_last = head[$bits(byte_t)];
    assign rd_user = head[$bits(byte_t)+1];
    assign rd_valid = rd_valid_reg;

    always_ff @(posedge clk_125mhz) begin
        if (wr_fire) begin
            mem[wr_ptr[ADDR_W-1:0]] <= {wr_user, wr_last, wr_data};
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            rd_valid_reg <= 1'b0;
        end else begin
            wr_ptr <= wr_ptr_nxt;
            rd_ptr <= rd_ptr_nxt;
            // Not empty after this edge, so a written byte shows one cycle later
            rd_valid_reg <= (wr_ptr_nxt != rd_ptr_nxt);
        end
    end

endmodule

`default_nettype wire

//--- rtl/udp_rx_filter.sv
// Input side of the echo core: matches the destination port of each
// parsed UDP header and steers the payload into the buffer or discards it

`timescale 1ns/1ps
`default_nettype none

module udp_rx_filter import udp_echo_pkg::*; #(
    parameter udp_port_t ECHO_PORT = DEFAULT_ECHO_PORT
) (
    input  logic        clk_125mhz,
    input  logic        rst_125mhz,

    // Parsed UDP header in
    input  logic        rx_hdr_valid,
    output logic        rx_hdr_ready,
    input  ip_addr_t    rx_source_ip,
    input  udp_port_t   rx_source_port,
    input  udp_port_t   rx_dest_port,
    input  udp_length_t rx_length,

    // Payload in
    input  byte_t       rx_payload_tdata,
    input  logic        rx_payload_tvalid,
    output logic        rx_payload_tready,
    input  logic        rx_payload_tlast,
    input  logic        rx_payload_tuser,

    // Reply header to the reply stage
    output logic        echo_hdr_valid,
    input  logic        echo_hdr_ready,
    output ip_addr_t    echo_dest_ip,
    output udp_port_t   echo_source_port,
    output udp_port_t   echo_dest_port,
    output udp_length_t echo_length,

    // Payload into the buffer
    output byte_t       wr_data,
    output logic        wr_last,
    output logic        wr_user,
    output logic        wr_valid,
    input  logic        wr_ready
);

    logic port_match;
    logic hdr_fire;
    logic last_fire;

    // A header has been taken and its payload is not finished yet
    logic frame_pending;
    // The pending frame goes to the buffer
    logic frame_match;

    assign port_match = (rx_dest_port == ECHO_PORT);

    // Matching headers also need room in the reply stage,
    // others are taken as soon as the previous frame is done
    assign rx_hdr_ready = !frame_pending && (!port_match || echo_hdr_ready);
    assign hdr_fire = rx_hdr_valid && rx_hdr_ready;

    // Reply header with the ports swapped, back to the sender
    assign echo_hdr_valid = rx_hdr_valid && !frame_pending && port_match;
    assign echo_dest_ip = rx_source_ip;
    assign echo_source_port = rx_dest_port;
    assign echo_dest_port = rx_source_port;
    assign echo_length = rx_length;

    // Dropped frames are sunk at full rate
    assign rx_payload_tready = frame_pending && (frame_match ? wr_ready : 1'b1);
    assign last_fire = rx_payload_tvalid && rx_payload_tready && rx_payload_tlast;

    assign wr_data = rx_payload_tdata;
    assign wr_last = rx_payload_tlast;
    assign wr_user = rx_payload_tuser;
    assign wr_valid = rx_payload_tvalid && frame_pending && frame_match;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            frame_pending <= 1'b0;
            frame_match <= 1'b0;
        end else begin
            if (hdr_fire) begin
                frame_pending <= 1'b1;
                frame_match <= port_match;
            end else if (last_fire) begin
                frame_pending <= 1'b0;
                frame_match <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the echo core bench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_udp_echo -f udp_echo.f &&
./obj_dir/Vtb_udp_echo | tee /dev/stderr | grep -q "Simulation passed" ||
{ echo "echo core simulation did not pass" >&2; exit 1; }

//--- udp_echo.f
rtl/udp_echo_pkg.sv
rtl/udp_rx_filter.sv
rtl/udp_payload_fifo.sv
rtl/udp_echo_tx.sv
rtl/udp_echo_top.sv
bench/clock_gen.sv
bench/udp_echo_properties.sv
bench/tb_udp_echo.sv
